/* all.f */
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_cfg.sv
verilog/icache_axi_read.sv
verilog/icache_array.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
test/axi_mem_model.sv
test/tb_icache.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with verilator and run it, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_icache -Mdir obj_dir &&
./obj_dir/Vtb_icache ||
{ echo "build or simulation failed" >&2; exit 1; }

/* test/axi_mem_model.sv */
`include "icache_defs.svh"

module axi_mem_model
    import icache_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic [1:0]  stall_i,      // 0 = never stall, 3 = ready one cycle in four
    input  axi_ar_t     ar_i,
    output logic        ar_ready_o,
    output axi_r_t      r_o,
    input  logic        r_ready_i,
    output logic [31:0] ar_count_o,   // accepted ar requests since reset
    output logic [31:0] last_addr_o,  // fields of the latest ar
    output logic [7:0]  last_len_o,
    output logic [2:0]  last_size_o
);

    integer      seed;
    logic [31:0] rnd;
    logic        go;          // this cycle's draw, 1 = no stall
    logic        busy;        // burst in progress
    logic [31:0] beat_addr;   // next beat to put on r, 8-byte aligned
    logic [8:0]  beats_left;

    // lower lane is the word at the beat address, upper lane the word after it
    function automatic logic [63:0] beat_at(input logic [31:0] addr);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = {2'b00, addr[31:2]} ^ 32'h1357_9bdf;
        hi = {2'b00, addr[31:2] + 30'd1} ^ 32'h1357_9bdf;
        return {hi, lo};
    endfunction

    initial seed = 82635;

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            ar_ready_o  <= 1'b0;
            r_o         <= '0;
            ar_count_o  <= '0;
            last_addr_o <= '0;
            last_len_o  <= '0;
            last_size_o <= '0;
            busy        <= 1'b0;
            beat_addr   <= '0;
            beats_left  <= '0;
        end else begin
            rnd = $random(seed);
            go  = (rnd[1:0] >= stall_i);
            if (!busy) begin
                if (ar_i.valid && ar_ready_o) begin  // ar handshake
                    busy        <= 1'b1;
                    ar_ready_o  <= 1'b0;
                    beat_addr   <= {ar_i.addr[31:3], 3'b000};
                    beats_left  <= {1'b0, ar_i.len} + 9'd1;
                    ar_count_o  <= ar_count_o + 32'd1;
                    last_addr_o <= ar_i.addr;
                    last_len_o  <= ar_i.len;
                    last_size_o <= ar_i.size;
                end else begin
                    ar_ready_o <= go;  // ready may come before valid
                end
            end else if (!r_o.valid || r_ready_i) begin  // r bus free after this edge
                if (r_o.valid && r_o.last) begin
                    busy      <= 1'b0;
                    r_o.valid <= 1'b0;
                end else if (beats_left != 9'd0 && go) begin
                    r_o.valid  <= 1'b1;
                    r_o.data   <= beat_at(beat_addr);
                    r_o.last   <= (beats_left == 9'd1);
                    beat_addr  <= beat_addr + 32'd8;
                    beats_left <= beats_left - 9'd1;
                end else begin
                    r_o.valid <= 1'b0;  // gap
                end
            end
        end
    end

endmodule

/* test/tb_icache.sv */
`include "icache_defs.svh"

module tb_icache
    import icache_pkg::*;
();

    localparam int WAIT_MAX = 500;  // cycles before a wait gives up

    logic                      clock;
    logic                      reset;
    logic                      cfg_we;
    icache_cfg_t               cfg_wdata;
    logic                      fetch_req;
    logic [31:0]               fetch_addr;
    logic                      fetch_ready;
    logic                      fetch_valid;
    logic [31:0]               fetch_instr;
    axi_ar_t                   axi_ar;
    logic                      axi_ar_ready;
    axi_r_t                    axi_r;
    logic                      axi_r_ready;
    logic [1:0]                stall;
    logic [31:0]               ar_count;
    logic [31:0]               last_addr;
    logic [7:0]                last_len;
    logic [2:0]                last_size;

    integer                    seed;
    logic [31:0]               exp_q[$];                    // words the dut still owes
    logic [`ICACHE_TAG_W-1:0]  shadow_tag [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]   shadow_valid;
    logic                      cache_on;                    // copy of the enable bit
    int                        exp_ar;                      // ar requests expected so far

    icache_top i_dut (
        .clock (clock), .reset (reset),
        .cfg_we_i (cfg_we), .cfg_wdata_i (cfg_wdata),
        .fetch_req_i (fetch_req), .fetch_addr_i (fetch_addr),
        .fetch_ready_o (fetch_ready), .fetch_valid_o (fetch_valid),
        .fetch_instr_o (fetch_instr),
        .axi_ar_o (axi_ar), .axi_ar_ready_i (axi_ar_ready),
        .axi_r_i (axi_r), .axi_r_ready_o (axi_r_ready)
    );

    axi_mem_model i_mem (
        .clock (clock), .reset (reset), .stall_i (stall),
        .ar_i (axi_ar), .ar_ready_o (axi_ar_ready),
        .r_o (axi_r), .r_ready_i (axi_r_ready),
        .ar_count_o (ar_count), .last_addr_o (last_addr),
        .last_len_o (last_len), .last_size_o (last_size)
    );

    always #4 clock = ~clock;

    // memory contents, word address xor a constant
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {2'b00, addr[31:2]} ^ 32'h1357_9bdf;
    endfunction

    // direct mapped prediction, tag [31:11] index [10:5], a miss installs the line
    function automatic bit shadow_hit(input logic [31:0] addr);
        if (shadow_valid[addr[10:5]] && shadow_tag[addr[10:5]] == addr[31:11]) return 1'b1;
        shadow_valid[addr[10:5]] = 1'b1;
        shadow_tag[addr[10:5]]   = addr[31:11];
        return 1'b0;
    endfunction

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic write_cfg(input logic en, input logic fl);
        @(posedge clock);
        cfg_we           <= 1'b1;
        cfg_wdata.enable <= en;
        cfg_wdata.flush  <= fl;
        @(posedge clock);
        cfg_we <= 1'b0;
        @(posedge clock);   // flush pulse reaches the array
        cache_on = en;
        if (fl) shadow_valid = '0;
    endtask

    // one fetch, waits for ready and valid, then checks the ar side
    task automatic run_fetch(input logic [31:0] addr);
        int          waited;
        int          latency;
        bit          hit;
        logic [31:0] ar_before;
        hit       = cache_on ? shadow_hit(addr) : 1'b0;
        ar_before = ar_count;
        waited    = 0;
        @(posedge clock);
        while (!fetch_ready) begin
            waited++;
            if (waited > WAIT_MAX) begin
                $display("fetch_ready_o stayed low, fetch of 0x%h never issued", addr);
                stop_on_error();
            end
            @(posedge clock);
        end
        exp_q.push_back(mem_word(addr));
        fetch_req  <= 1'b1;
        fetch_addr <= addr;
        @(posedge clock);     // accepted on this edge
        fetch_req <= 1'b0;
        latency = 0;
        do begin
            @(posedge clock);
            latency++;
            if (latency > WAIT_MAX) begin
                $display("no fetch_valid_o for address 0x%h", addr);
                stop_on_error();
            end
        end while (!fetch_valid);
        if (hit) begin
            check("fetch_valid_o latency", 64'(latency), 64'd1);
            check("ar_count_o", ar_count, ar_before);   // no traffic on a hit
        end else begin
            exp_ar++;
            check("ar_count_o", ar_count, ar_before + 32'd1);
            if (cache_on) begin
                check("axi_ar_o.len", last_len, `ICACHE_LINE_LEN);
                check("axi_ar_o.size", last_size, `AXI_SIZE_8B);
                check("axi_ar_o.addr", last_addr, {addr[31:5], 5'b00000});
            end else begin
                check("axi_ar_o.len", last_len, 8'd0);
                check("axi_ar_o.size", last_size, `AXI_SIZE_4B);
                check("axi_ar_o.addr", last_addr, addr);
            end
        end
    endtask

    // result checker, every valid pulse owes one queued word
    always @(posedge clock) begin
        if (reset && fetch_valid) begin
            if (exp_q.size() == 0) begin
                $display("fetch_valid_o pulsed with no fetch outstanding");
                stop_on_error();
            end else begin
                check("fetch_instr_o", fetch_instr, exp_q.pop_front());
            end
        end
        if (reset && axi_ar.valid) begin
            check("axi_ar_o.burst", axi_ar.burst, `AXI_BURST_INCR);  // incr on every request
        end
    end

    initial begin
        logic [31:0] base;
        clock        = 1'b0;
        reset        = 1'b0;
        cfg_we       = 1'b0;
        cfg_wdata    = '0;
        fetch_req    = 1'b0;
        fetch_addr   = '0;
        stall        = 2'd0;
        seed         = 82635;
        cache_on     = 1'b0;
        shadow_valid = '0;
        exp_ar       = 0;
        repeat (5) @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);

        check("fetch_ready_o", fetch_ready, 1);   // idle after reset
        check("fetch_valid_o", fetch_valid, 0);
        check("axi_ar_o.valid", axi_ar.valid, 0);
        check("axi_r_ready_o", axi_r_ready, 0);

        write_cfg(1'b1, 1'b0);
        base = 32'h0000_1240;
        run_fetch(base + 32'h14);                 // mid-line miss, refill from line start
        for (int i = 0; i < 8; i++) begin
            if (i != 5) run_fetch(base + 32'(4 * i));
        end

        for (int n = 0; n < 200; n++) begin
            if (n % 25 == 0) stall <= 2'($random(seed));
            run_fetch($random(seed) & 32'h0000_3ffc);   // 16 KB window, 8x the cache
        end
        check("ar_count_o", ar_count, 32'(exp_ar));

        write_cfg(1'b0, 1'b0);                    // uncached, both halves of a beat
        for (int n = 0; n < 8; n++) begin
            run_fetch(32'h0000_8000 + 32'(n * 36));
        end
        write_cfg(1'b1, 1'b0);
        run_fetch(32'h0000_8024);                 // never filled, so a refill

        run_fetch(32'h0000_0400);
        run_fetch(32'h0000_0404);                 // line now resident
        write_cfg(1'b1, 1'b1);
        run_fetch(32'h0000_0408);                 // gone after flush

        check("ar_count_o", ar_count, 32'(exp_ar));
        repeat (2) @(posedge clock);
        if (exp_q.size() != 0) begin
            $display("%0d fetch results never arrived", exp_q.size());
            stop_on_error();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* verilog/icache_array.sv */
`include "icache_defs.svh"

module icache_array
    import icache_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       flush_i,        // clears every valid bit
    // lookup, result one cycle later
    input  logic                       lookup_en_i,
    input  fetch_addr_u                lookup_addr_i,
    output logic                       hit_o,
    output logic [`ICACHE_INSTR_W-1:0] rdata_o,
    // refill write port
    input  logic                       fill_we_i,      // one beat
    input  fetch_addr_u                fill_addr_i,
    input  logic [`ICACHE_DATA_W-1:0]  fill_data_i,
    input  logic                       fill_done_i     // line complete, set tag+valid
);

    localparam int DATA_DEPTH = `ICACHE_SETS * `ICACHE_BEATS;

    logic [`ICACHE_SETS-1:0]   valid_q;                    // one bit per set
    logic [`ICACHE_TAG_W-1:0]  tag_mem [`ICACHE_SETS];
    logic [`ICACHE_DATA_W-1:0] data_mem [DATA_DEPTH];      // {index, beat} addressed

    logic [`ICACHE_IDX_W+`ICACHE_BEAT_W-1:0] lookup_word;
    logic [`ICACHE_IDX_W+`ICACHE_BEAT_W-1:0] fill_word;
    logic [`ICACHE_DATA_W-1:0]              lookup_beat;

    logic                       hit_q;
    logic [`ICACHE_INSTR_W-1:0] rdata_q;

    assign lookup_word = {lookup_addr_i.f.index, lookup_addr_i.f.beat};
    assign fill_word   = {fill_addr_i.f.index, fill_addr_i.f.beat};
    assign lookup_beat = data_mem[lookup_word];

    // valid bits, flush wins over a line completing the same cycle
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (fill_done_i) begin
            valid_q[fill_addr_i.f.index] <= 1'b1;
        end
    end

    // tag written once per line, at the end of the refill
    always_ff @(posedge clock) begin
        if (fill_done_i) begin
            tag_mem[fill_addr_i.f.index] <= fill_addr_i.f.tag;
        end
    end

    // beat store
    always_ff @(posedge clock) begin
        if (fill_we_i) begin
            data_mem[fill_word] <= fill_data_i;
        end
    end

    // registered compare, holds between lookups
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            hit_q <= 1'b0;
        end else if (lookup_en_i) begin
            hit_q <= valid_q[lookup_addr_i.f.index] &&
                     (tag_mem[lookup_addr_i.f.index] == lookup_addr_i.f.tag);
        end
    end

    // pick the 32-bit half of the beat, little endian lanes
    always_ff @(posedge clock) begin
        if (lookup_en_i) begin
            rdata_q <= lookup_addr_i.f.half ? lookup_beat[`ICACHE_DATA_W-1:`ICACHE_INSTR_W]
                                            : lookup_beat[`ICACHE_INSTR_W-1:0];
        end
    end

    assign hit_o   = hit_q;
    assign rdata_o = rdata_q;

endmodule

/* verilog/icache_axi_read.sv */
`include "icache_defs.svh"

module icache_axi_read
    import icache_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    // request side, from the controller
    input  logic                      rd_req_i,     // taken only while rd_ready_o
    input  fetch_addr_u               rd_addr_i,
    input  logic [7:0]                rd_len_i,     // 0 = single word, 3 = line
    output logic                      rd_ready_o,
    // returned beats, straight from the r channel
    output logic                      beat_valid_o,
    output logic [`ICACHE_DATA_W-1:0] beat_data_o,
    output logic                      beat_last_o,
    // axi read channels
    output axi_ar_t                   axi_ar_o,
    input  logic                      axi_ar_ready_i,
    input  axi_r_t                    axi_r_i,
    output logic                      axi_r_ready_o
);

    // gray-ish encoding, one bit flips per step
    localparam logic [1:0] R_IDLE    = 2'b00;
    localparam logic [1:0] R_AR_WAIT = 2'b01;
    localparam logic [1:0] R_R_WAIT  = 2'b11;
    localparam logic [1:0] R_DONE    = 2'b10;

    logic [1:0]  state_q;
    logic [1:0]  state_d;
    fetch_addr_u addr_q;   // held for the whole ar handshake
    logic [7:0]  len_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= R_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            R_IDLE: begin
                if (rd_req_i) state_d = R_AR_WAIT;  // ar valid next cycle
            end
            R_AR_WAIT: begin
                if (axi_ar_ready_i) state_d = R_R_WAIT;
            end
            R_R_WAIT: begin
                // last alone is not enough, it must come with valid
                if (axi_r_i.valid && axi_r_i.last) state_d = R_DONE;
            end
            R_DONE: begin
                state_d = R_IDLE;  // one quiet cycle between bursts
            end
            default: begin
                state_d = R_IDLE;
            end
        endcase
    end

    // latch the request while idle, ar fields must not move while valid
    always_ff @(posedge clock) begin
        if (state_q == R_IDLE && rd_req_i) begin
            addr_q <= rd_addr_i;
            len_q  <= rd_len_i;
        end
    end

    assign rd_ready_o = (state_q == R_IDLE);

    // ar channel
    assign axi_ar_o.valid = (state_q == R_AR_WAIT);
    assign axi_ar_o.addr  = addr_q.raw;
    assign axi_ar_o.len   = len_q;
    assign axi_ar_o.size  = (len_q == 8'd0) ? `AXI_SIZE_4B : `AXI_SIZE_8B;  // narrow if single
    assign axi_ar_o.burst = `AXI_BURST_INCR;

    // r channel, ready for the whole data phase
    assign axi_r_ready_o = (state_q == R_R_WAIT);

    // beats pass through combinationally, resp is dropped
    assign beat_valid_o = axi_r_i.valid & axi_r_ready_o;
    assign beat_data_o  = axi_r_i.data;
    assign beat_last_o  = axi_r_i.last;

endmodule

/* verilog/icache_cfg.sv */
module icache_cfg
    import icache_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        cfg_we_i,     // write strobe
    input  icache_cfg_t cfg_wdata_i,
    output logic        enable_o,     // steers ctrl between cached and uncached
    output logic        flush_o       // one cycle, to the array
);

    logic enable_q;
    logic flush_q;

    // enable is sticky until the next write
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            enable_q <= 1'b0;  // cache off out of reset
        end else if (cfg_we_i) begin
            enable_q <= cfg_wdata_i.enable;
        end
    end

    // flush bit is not stored, only pulsed once per write
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= cfg_we_i & cfg_wdata_i.flush;  // drops again next cycle
        end
    end

    assign enable_o = enable_q;
    assign flush_o  = flush_q;

    // note a write with enable=0 and flush=1 both turns the cache off and
    // invalidates, so re-enabling later starts from a clean array

endmodule

/* verilog/icache_ctrl.sv */
`include "icache_defs.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       enable_i,       // 0 = every fetch goes to axi
    // cpu fetch port
    input  logic                       fetch_req_i,
    input  fetch_addr_u                fetch_addr_i,
    output logic                       fetch_ready_o,
    output logic                       fetch_valid_o,
    output logic [`ICACHE_INSTR_W-1:0] fetch_instr_o,
    // array
    output logic                       lookup_en_o,
    output fetch_addr_u                lookup_addr_o,
    input  logic                       hit_i,
    input  logic [`ICACHE_INSTR_W-1:0] rdata_i,
    output logic                       fill_we_o,
    output fetch_addr_u                fill_addr_o,
    output logic [`ICACHE_DATA_W-1:0]  fill_data_o,
    output logic                       fill_done_o,
    // axi master
    output logic                       rd_req_o,
    output fetch_addr_u                rd_addr_o,
    output logic [7:0]                 rd_len_o,
    input  logic                       rd_ready_i,
    input  logic                       beat_valid_i,
    input  logic [`ICACHE_DATA_W-1:0]  beat_data_i,
    input  logic                       beat_last_i
);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_LOOKUP   = 3'd1;  // array result visible
    localparam logic [2:0] S_REQ      = 3'd2;  // waiting for the master to take rd_req
    localparam logic [2:0] S_REFILL   = 3'd3;
    localparam logic [2:0] S_RELOOKUP = 3'd4;
    localparam logic [2:0] S_UNCACHED = 3'd5;

    logic [2:0]                 state_q;
    logic [2:0]                 state_d;
    fetch_addr_u                addr_q;       // fetch in progress
    logic                       uncached_q;   // enable sampled at accept
    logic [`ICACHE_BEAT_W-1:0]  beat_cnt_q;   // next beat slot to fill
    logic                       unc_done_q;   // uncached word ready
    logic [`ICACHE_INSTR_W-1:0] instr_q;
    logic                       accept;
    logic                       beat_end;

    assign accept   = (state_q == S_IDLE) && fetch_req_i;
    assign beat_end = beat_valid_i && beat_last_i;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:     if (fetch_req_i) state_d = enable_i ? S_LOOKUP : S_REQ;
            S_LOOKUP:   state_d = hit_i ? S_IDLE : S_REQ;
            S_REQ:      if (rd_ready_i) state_d = uncached_q ? S_UNCACHED : S_REFILL;
            S_REFILL:   if (beat_end) state_d = S_RELOOKUP;
            S_RELOOKUP: state_d = S_LOOKUP;   // read back the fresh line
            S_UNCACHED: if (beat_end) state_d = S_IDLE;
            default:    state_d = S_IDLE;
        endcase
    end

    // request latch, payload only
    always_ff @(posedge clock) begin
        if (accept) addr_q <= fetch_addr_i;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            uncached_q <= 1'b0;
            beat_cnt_q <= '0;
            unc_done_q <= 1'b0;
        end else begin
            if (accept) uncached_q <= !enable_i;
            if (state_q == S_REQ) beat_cnt_q <= '0;      // restart at beat 0
            else if (fill_we_o) beat_cnt_q <= beat_cnt_q + 1'b1;
            unc_done_q <= (state_q == S_UNCACHED) && beat_end;  // answer one cycle later
        end
    end

    // bit 2 picks the half, the slave drives the narrow word on its own lanes
    always_ff @(posedge clock) begin
        if (state_q == S_UNCACHED && beat_end) begin
            instr_q <= addr_q.f.half ? beat_data_i[`ICACHE_DATA_W-1:`ICACHE_INSTR_W]
                                     : beat_data_i[`ICACHE_INSTR_W-1:0];
        end
    end

    // lookup on accept when cached, and again after a refill
    assign lookup_en_o   = (accept && enable_i) || (state_q == S_RELOOKUP);
    assign lookup_addr_o = (state_q == S_RELOOKUP) ? addr_q : fetch_addr_i;

    // axi request, line aligned burst or single word
    always_comb begin
        rd_addr_o            = addr_q;
        rd_addr_o.f.byte_sel = '0;
        if (!uncached_q) begin
            rd_addr_o.f.beat = '0;
            rd_addr_o.f.half = 1'b0;
        end
    end
    assign rd_req_o = (state_q == S_REQ);  // held until rd_ready, leaves the same cycle
    assign rd_len_o = uncached_q ? 8'd0 : `ICACHE_LINE_LEN;

    // refill writes, beat slot counts up from 0
    always_comb begin
        fill_addr_o            = addr_q;
        fill_addr_o.f.beat     = beat_cnt_q;
        fill_addr_o.f.half     = 1'b0;
        fill_addr_o.f.byte_sel = '0;
    end
    assign fill_we_o   = (state_q == S_REFILL) && beat_valid_i;
    assign fill_data_o = beat_data_i;
    assign fill_done_o = fill_we_o && beat_last_i;  // tag and valid with the last beat

    // cpu side
    assign fetch_ready_o = (state_q == S_IDLE);
    assign fetch_valid_o = ((state_q == S_LOOKUP) && hit_i) || unc_done_q;
    assign fetch_instr_o = unc_done_q ? instr_q : rdata_i;

endmodule

/* verilog/icache_defs.svh */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// fetch and axi address width
`define ICACHE_ADDR_W 32

// axi read data bus, one beat
`define ICACHE_DATA_W 64

// instruction word, half a beat
`define ICACHE_INSTR_W 32

// line geometry
`define ICACHE_BEATS 4     // beats per line, 32 bytes
`define ICACHE_BEAT_W 2    // beat index bits
`define ICACHE_SETS 64     // direct mapped
`define ICACHE_IDX_W 6     // set index bits
`define ICACHE_TAG_W 21    // 32 - 6 - 2 - 1 - 2

// axi arlen of a line refill (len minus one)
`define ICACHE_LINE_LEN 8'd3

// axi burst type code
`define AXI_BURST_INCR 2'b01

// axi arsize codes
`define AXI_SIZE_4B 3'd2   // uncached single word
`define AXI_SIZE_8B 3'd3   // full bus beat

`endif

/* verilog/icache_pkg.sv */
`include "icache_defs.svh"

package icache_pkg;

    // one fetch address, flat or split into cache fields
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] raw;       // byte address as seen on axi
        struct packed {
            logic [`ICACHE_TAG_W-1:0]  tag;      // upper bits compared on lookup
            logic [`ICACHE_IDX_W-1:0]  index;    // set select
            logic [`ICACHE_BEAT_W-1:0] beat;     // 64-bit beat inside the line
            logic                      half;     // 32-bit half inside the beat
            logic [1:0]                byte_sel; // always zero for fetches
        } f;
    } fetch_addr_u;

    // read address channel, master to slave
    typedef struct packed {
        logic                      valid;
        logic [`ICACHE_ADDR_W-1:0] addr;
        logic [7:0]                len;   // beats minus one
        logic [2:0]                size;  // log2 bytes per beat
        logic [1:0]                burst;
    } axi_ar_t;

    // read data channel, slave to master
    typedef struct packed {
        logic                      valid;
        logic [`ICACHE_DATA_W-1:0] data;
        logic [1:0]                resp;  // carried, not checked
        logic                      last;
    } axi_r_t;

    // config write data
    typedef struct packed {
        logic enable;  // 1 = cached fetches
        logic flush;   // 1 = drop all lines
    } icache_cfg_t;

endpackage

/* verilog/icache_top.sv */
`include "icache_defs.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    // config port
    input  logic                       cfg_we_i,
    input  icache_cfg_t                cfg_wdata_i,
    // cpu fetch port
    input  logic                       fetch_req_i,
    input  logic [`ICACHE_ADDR_W-1:0]  fetch_addr_i,
    output logic                       fetch_ready_o,
    output logic                       fetch_valid_o,
    output logic [`ICACHE_INSTR_W-1:0] fetch_instr_o,
    // axi read master, id/prot/cache etc. tied off outside
    output axi_ar_t                    axi_ar_o,
    input  logic                       axi_ar_ready_i,
    input  axi_r_t                     axi_r_i,
    output logic                       axi_r_ready_o
);

    fetch_addr_u                fetch_addr;   // raw in, fields inside
    logic                       enable;
    logic                       flush;
    logic                       lookup_en;
    fetch_addr_u                lookup_addr;
    logic                       hit;
    logic [`ICACHE_INSTR_W-1:0] rdata;
    logic                       fill_we;
    fetch_addr_u                fill_addr;
    logic [`ICACHE_DATA_W-1:0]  fill_data;
    logic                       fill_done;
    logic                       rd_req;
    fetch_addr_u                rd_addr;
    logic [7:0]                 rd_len;
    logic                       rd_ready;
    logic                       beat_valid;
    logic [`ICACHE_DATA_W-1:0]  beat_data;
    logic                       beat_last;

    assign fetch_addr.raw = fetch_addr_i;

    icache_cfg i_cfg (
        .clock       (clock),
        .reset       (reset),
        .cfg_we_i    (cfg_we_i),
        .cfg_wdata_i (cfg_wdata_i),
        .enable_o    (enable),
        .flush_o     (flush)
    );

    icache_ctrl i_ctrl (
        .clock (clock), .reset (reset), .enable_i (enable),
        .fetch_req_i (fetch_req_i), .fetch_addr_i (fetch_addr),
        .fetch_ready_o (fetch_ready_o), .fetch_valid_o (fetch_valid_o),
        .fetch_instr_o (fetch_instr_o),
        .lookup_en_o (lookup_en), .lookup_addr_o (lookup_addr),
        .hit_i (hit), .rdata_i (rdata),
        .fill_we_o (fill_we), .fill_addr_o (fill_addr),
        .fill_data_o (fill_data), .fill_done_o (fill_done),
        .rd_req_o (rd_req), .rd_addr_o (rd_addr), .rd_len_o (rd_len),
        .rd_ready_i (rd_ready), .beat_valid_i (beat_valid),
        .beat_data_i (beat_data), .beat_last_i (beat_last)
    );

    icache_array i_array (
        .clock (clock), .reset (reset), .flush_i (flush),
        .lookup_en_i (lookup_en), .lookup_addr_i (lookup_addr),
        .hit_o (hit), .rdata_o (rdata),
        .fill_we_i (fill_we), .fill_addr_i (fill_addr),
        .fill_data_i (fill_data), .fill_done_i (fill_done)
    );

    icache_axi_read i_axi_read (
        .clock (clock), .reset (reset),
        .rd_req_i (rd_req), .rd_addr_i (rd_addr), .rd_len_i (rd_len),
        .rd_ready_o (rd_ready), .beat_valid_o (beat_valid),
        .beat_data_o (beat_data), .beat_last_o (beat_last),
        .axi_ar_o (axi_ar_o), .axi_ar_ready_i (axi_ar_ready_i),
        .axi_r_i (axi_r_i), .axi_r_ready_o (axi_r_ready_o)
    );

endmodule
